// File: common/arm_exec_defines.svh
// Shared width and size macros for the execute stage
// Instruction field positions for data, memory and branch formats
`ifndef ARM_EXEC_DEFINES_SVH
`define ARM_EXEC_DEFINES_SVH

// Data path and data memory geometry
`define ARM_WORD_WIDTH 32
`define ARM_DATA_SIZE 256
`define ARM_DATA_ADDR_WIDTH 8

// Fields common to all formats
`define ARM_COND_FIELD 31:28
`define ARM_FORMAT_FIELD 27:26
`define ARM_IMM_BIT 25

// Data processing fields
`define ARM_OPCODE_FIELD 24:21
`define ARM_SET_FLAGS_BIT 20
`define ARM_RN_FIELD 19:16

// Memory fields with the load bit in the S position
`define ARM_LOAD_BIT 20
`define ARM_UP_BIT 23
`define ARM_OFFSET12_FIELD 11:0

// Shifted register operand
`define ARM_SHIFT_AMOUNT_FIELD 11:7
`define ARM_SHIFT_TYPE_FIELD 6:5

// Rotated immediate operand
`define ARM_ROTATE_FIELD 11:8
`define ARM_IMM8_FIELD 7:0

// Branch fields
`define ARM_LINK_BIT 24
`define ARM_BRANCH_OFFSET_FIELD 23:0
`define ARM_BRANCH_OFFSET_WIDTH 24

`endif

// File: common/arm_exec_pkg.sv
// Types shared by the execute stage
// Word, flag record, opcode, condition, shift and format encodings
`default_nettype none

`include "arm_exec_defines.svh"

package arm_exec_pkg;

    typedef logic [`ARM_WORD_WIDTH-1:0] word_t;

    // Subset of the CPSR that the stage keeps
    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

    // ARM data processing encodings, unsupported values fall to default
    typedef enum logic [3:0] {
        OP_EOR = 4'd1,
        OP_SUB = 4'd2,
        OP_ADD = 4'd4,
        OP_TST = 4'd8,
        OP_TEQ = 4'd9,
        OP_CMP = 4'd10,
        OP_ORR = 4'd12,
        OP_MOV = 4'd13,
        OP_BIC = 4'd14,
        OP_MVN = 4'd15
    } opcode_t;

    typedef enum logic [3:0] {
        COND_EQ = 4'd0,
        COND_NE = 4'd1,
        COND_CS = 4'd2,
        COND_CC = 4'd3,
        COND_MI = 4'd4,
        COND_PL = 4'd5,
        COND_VS = 4'd6,
        COND_VC = 4'd7,
        COND_HI = 4'd8,
        COND_LS = 4'd9,
        COND_GE = 4'd10,
        COND_LT = 4'd11,
        COND_GT = 4'd12,
        COND_LE = 4'd13,
        COND_AL = 4'd14
    } cond_t;

    typedef enum logic [1:0] {
        SHIFT_LSL = 2'd0,
        SHIFT_LSR = 2'd1,
        SHIFT_ASR = 2'd2,
        SHIFT_ROR = 2'd3
    } shift_t;

    typedef enum logic [1:0] {
        FMT_DATA   = 2'd0,
        FMT_MEMORY = 2'd1,
        FMT_BRANCH = 2'd2
    } format_t;

endpackage

`default_nettype wire

// File: alu/operand_shifter.sv
// Barrel shifter for operand 2 and the memory offset
// Rotated immediate, shifted Rm, 12-bit offset with up/down sign
`timescale 1ns/1ps
`default_nettype none

`include "arm_exec_defines.svh"

module operand_shifter (
    input  arm_exec_pkg::word_t inst,
    input  arm_exec_pkg::word_t rm_value,
    input  logic                is_memory,
    output arm_exec_pkg::word_t operand
);

    // Rotate through a doubled word, so an amount of zero is a no-op
    function automatic arm_exec_pkg::word_t rotate_right(
        input arm_exec_pkg::word_t value,
        input logic [4:0]          amount
    );
        logic [2*`ARM_WORD_WIDTH-1:0] doubled;
        doubled = {value, value} >> amount;
        return doubled[`ARM_WORD_WIDTH-1:0];
    endfunction

    logic [4:0]           shift_amount;
    arm_exec_pkg::shift_t shift_type;
    arm_exec_pkg::word_t  shifted_rm;
    arm_exec_pkg::word_t  rotated_imm;
    arm_exec_pkg::word_t  offset;

    assign shift_amount = inst[`ARM_SHIFT_AMOUNT_FIELD];
    assign shift_type   = arm_exec_pkg::shift_t'(inst[`ARM_SHIFT_TYPE_FIELD]);

    always_comb begin
        case (shift_type)
            arm_exec_pkg::SHIFT_LSL: shifted_rm = rm_value << shift_amount;
            arm_exec_pkg::SHIFT_LSR: shifted_rm = rm_value >> shift_amount;
            arm_exec_pkg::SHIFT_ASR:
                shifted_rm = arm_exec_pkg::word_t'($signed(rm_value) >>> shift_amount);
            default: shifted_rm = rotate_right(rm_value, shift_amount); // ROR
        endcase
    end

    // 8-bit immediate rotated right by twice the rotate field
    assign rotated_imm = rotate_right({{(`ARM_WORD_WIDTH-8){1'b0}}, inst[`ARM_IMM8_FIELD]},
                                      {inst[`ARM_ROTATE_FIELD], 1'b0});

    // Memory: bit 25 clear selects the 12-bit immediate
    assign offset = inst[`ARM_IMM_BIT] ? shifted_rm
                                       : {{(`ARM_WORD_WIDTH-12){1'b0}}, inst[`ARM_OFFSET12_FIELD]};

    always_comb begin
        if (is_memory) begin
            operand = inst[`ARM_UP_BIT] ? offset : -offset; // Down means subtract from Rn
        end else begin
            operand = inst[`ARM_IMM_BIT] ? rotated_imm : shifted_rm;
        end
    end

endmodule

`default_nettype wire

// File: alu/dataproc_alu.sv
// Data processing ALU
// Ten ARM operations, Rd write-back decision and new NZCV flags
`timescale 1ns/1ps
`default_nettype none

`include "arm_exec_defines.svh"

module dataproc_alu (
    input  arm_exec_pkg::opcode_t opcode,
    input  arm_exec_pkg::word_t   rn_value,
    input  arm_exec_pkg::word_t   operand2,
    input  arm_exec_pkg::flags_t  flags_in,
    output arm_exec_pkg::word_t   result,
    output logic                  writes_rd,
    output arm_exec_pkg::flags_t  flags_out
);

    localparam int W = `ARM_WORD_WIDTH;

    logic [W:0] sum;
    logic [W:0] diff;
    logic       add_overflow;
    logic       sub_overflow;
    logic       carry;
    logic       overflow;
    logic       supported;

    assign sum  = {1'b0, rn_value} + {1'b0, operand2};
    assign diff = {1'b0, rn_value} - {1'b0, operand2};

    // Signed overflow from operand and result sign bits
    assign add_overflow = (rn_value[W-1] == operand2[W-1]) && (sum[W-1] != rn_value[W-1]);
    assign sub_overflow = (rn_value[W-1] != operand2[W-1]) && (diff[W-1] != rn_value[W-1]);

    always_comb begin
        result    = rn_value;
        writes_rd = 1'b1;
        carry     = 1'b0;   // Logical ops clear C and V
        overflow  = 1'b0;
        supported = 1'b1;
        case (opcode)
            arm_exec_pkg::OP_EOR: result = rn_value ^ operand2;
            arm_exec_pkg::OP_SUB: begin
                result   = diff[W-1:0];
                carry    = ~diff[W];    // No borrow, Rn >= op2
                overflow = sub_overflow;
            end
            arm_exec_pkg::OP_ADD: begin
                result   = sum[W-1:0];
                carry    = sum[W];
                overflow = add_overflow;
            end
            arm_exec_pkg::OP_TST: begin
                result    = rn_value & operand2;
                writes_rd = 1'b0;
            end
            arm_exec_pkg::OP_TEQ: begin
                result    = rn_value ^ operand2;
                writes_rd = 1'b0;
            end
            arm_exec_pkg::OP_CMP: begin
                result    = diff[W-1:0];
                writes_rd = 1'b0;
                carry     = ~diff[W];
                overflow  = sub_overflow;
            end
            arm_exec_pkg::OP_ORR: result = rn_value | operand2;
            arm_exec_pkg::OP_MOV: result = operand2;
            arm_exec_pkg::OP_BIC: result = rn_value & ~operand2;
            arm_exec_pkg::OP_MVN: result = ~operand2;
            default: begin
                writes_rd = 1'b0;
                supported = 1'b0;
            end
        endcase
    end

    always_comb begin
        if (supported) begin
            flags_out.n = result[W-1];
            flags_out.z = (result == '0);
            flags_out.c = carry;
            flags_out.v = overflow;
        end else begin
            flags_out = flags_in;   // Unknown opcode leaves flags alone
        end
    end

endmodule

`default_nettype wire

// File: logic/condition_check.sv
// ARM condition code evaluation against the NZCV flags
`timescale 1ns/1ps
`default_nettype none

module condition_check (
    input  arm_exec_pkg::flags_t flags,
    input  arm_exec_pkg::cond_t  cond,
    output logic                 passes
);

    always_comb begin
        case (cond)
            arm_exec_pkg::COND_EQ: passes = flags.z;
            arm_exec_pkg::COND_NE: passes = ~flags.z;
            arm_exec_pkg::COND_CS: passes = flags.c;
            arm_exec_pkg::COND_CC: passes = ~flags.c;
            arm_exec_pkg::COND_MI: passes = flags.n;
            arm_exec_pkg::COND_PL: passes = ~flags.n;
            arm_exec_pkg::COND_VS: passes = flags.v;
            arm_exec_pkg::COND_VC: passes = ~flags.v;
            arm_exec_pkg::COND_HI: passes = flags.c & ~flags.z;     // Unsigned higher
            arm_exec_pkg::COND_LS: passes = ~flags.c | flags.z;     // Unsigned lower or same
            arm_exec_pkg::COND_GE: passes = (flags.n == flags.v);
            arm_exec_pkg::COND_LT: passes = (flags.n != flags.v);
            arm_exec_pkg::COND_GT: passes = ~flags.z & (flags.n == flags.v);
            arm_exec_pkg::COND_LE: passes = flags.z | (flags.n != flags.v);
            // AL and the reserved code 15
            default: passes = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/data_memory.sv
// Byte-addressed big-endian data memory
// Four-byte word writes, registered read address, wrapping addresses
`timescale 1ns/1ps
`default_nettype none

`include "arm_exec_defines.svh"

module data_memory (
    input  logic                            clk,
    input  logic                            nreset,
    input  logic                            write_en,
    input  logic [`ARM_DATA_ADDR_WIDTH-1:0] write_addr,
    input  arm_exec_pkg::word_t             write_data,
    input  logic                            read_en,
    input  logic [`ARM_DATA_ADDR_WIDTH-1:0] read_addr,
    output arm_exec_pkg::word_t             read_data
);

    localparam int AW = `ARM_DATA_ADDR_WIDTH;

    logic [7:0]    mem [0:`ARM_DATA_SIZE-1];
    logic [AW-1:0] read_addr_q;

    // Most significant byte at the lowest address
    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[write_addr]                 <= write_data[31:24];
            mem[write_addr + AW'(1)]        <= write_data[23:16];
            mem[write_addr + AW'(2)]        <= write_data[15:8];
            mem[write_addr + AW'(3)]        <= write_data[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (nreset) begin
            read_addr_q <= '0;
        end else if (read_en) begin
            read_addr_q <= read_addr;
        end
    end

    // Word assembled from the held address, offsets wrap at the top
    assign read_data = {mem[read_addr_q],
                        mem[read_addr_q + AW'(1)],
                        mem[read_addr_q + AW'(2)],
                        mem[read_addr_q + AW'(3)]};

endmodule

`default_nettype wire

// File: logic/executor.sv
// Execute stage top level
// Condition check, format dispatch, branch and address arithmetic,
// stage registers and Rd result selection
`timescale 1ns/1ps
`default_nettype none

`include "arm_exec_defines.svh"

module executor (
    input  logic                 clk,
    input  logic                 nreset,
    input  logic                 enable,
    input  arm_exec_pkg::word_t  decoder_inst,
    input  arm_exec_pkg::word_t  rn_value,
    input  arm_exec_pkg::word_t  rd_rm_value,   // Rd for STR, Rm otherwise
    input  arm_exec_pkg::word_t  pc,
    output logic                 ready,
    output arm_exec_pkg::flags_t cpsr,
    output logic                 condition_passes,
    output arm_exec_pkg::word_t  executor_inst,
    output logic                 update_pc,
    output arm_exec_pkg::word_t  new_pc,
    output logic                 update_rd,
    output arm_exec_pkg::word_t  rd_value
);

    localparam int BOW = `ARM_BRANCH_OFFSET_WIDTH;

    arm_exec_pkg::format_t fmt;
    arm_exec_pkg::word_t   operand;
    arm_exec_pkg::word_t   alu_result;
    arm_exec_pkg::flags_t  alu_flags;
    arm_exec_pkg::word_t   mem_addr_sum;
    arm_exec_pkg::word_t   mem_read_data;
    arm_exec_pkg::word_t   branch_offset;
    arm_exec_pkg::word_t   branch_target;
    arm_exec_pkg::word_t   link_value;
    arm_exec_pkg::word_t   next_result;
    arm_exec_pkg::word_t   result_q;
    logic                  alu_writes_rd;
    logic                  execute;
    logic                  is_data;
    logic                  is_memory_op;
    logic                  is_branch;
    logic                  is_link;
    logic                  mem_read_en;
    logic                  mem_write_en;
    logic                  next_update_rd;
    logic                  result_is_load;

    assign fmt = arm_exec_pkg::format_t'(decoder_inst[`ARM_FORMAT_FIELD]);

    // Flags of all earlier instructions are already in cpsr
    condition_check u_condition_check (
        .flags  (cpsr),
        .cond   (arm_exec_pkg::cond_t'(decoder_inst[`ARM_COND_FIELD])),
        .passes (condition_passes)
    );

    assign execute      = enable && condition_passes;
    assign is_data      = execute && (fmt == arm_exec_pkg::FMT_DATA);
    assign is_memory_op = execute && (fmt == arm_exec_pkg::FMT_MEMORY);
    assign is_branch    = execute && (fmt == arm_exec_pkg::FMT_BRANCH);
    assign is_link      = is_branch && decoder_inst[`ARM_LINK_BIT];

    operand_shifter u_operand_shifter (
        .inst      (decoder_inst),
        .rm_value  (rd_rm_value),
        .is_memory (fmt == arm_exec_pkg::FMT_MEMORY),
        .operand   (operand)
    );

    dataproc_alu u_dataproc_alu (
        .opcode    (arm_exec_pkg::opcode_t'(decoder_inst[`ARM_OPCODE_FIELD])),
        .rn_value  (rn_value),
        .operand2  (operand),
        .flags_in  (cpsr),
        .result    (alu_result),
        .writes_rd (alu_writes_rd),
        .flags_out (alu_flags)
    );

    // Offset already carries the up/down sign
    assign mem_addr_sum = rn_value + operand;
    assign mem_read_en  = is_memory_op && decoder_inst[`ARM_LOAD_BIT];
    // STR with a register offset is not executed
    assign mem_write_en = is_memory_op && !decoder_inst[`ARM_LOAD_BIT]
                          && !decoder_inst[`ARM_IMM_BIT];

    data_memory u_data_memory (
        .clk        (clk),
        .nreset     (nreset),
        .write_en   (mem_write_en),
        .write_addr (mem_addr_sum[`ARM_DATA_ADDR_WIDTH-1:0]),
        .write_data (rd_rm_value),
        .read_en    (mem_read_en),
        .read_addr  (mem_addr_sum[`ARM_DATA_ADDR_WIDTH-1:0]),
        .read_data  (mem_read_data)
    );

    // Word offset, sign-extended and scaled by 4
    assign branch_offset = {{(`ARM_WORD_WIDTH-BOW-2){decoder_inst[BOW-1]}},
                            decoder_inst[`ARM_BRANCH_OFFSET_FIELD], 2'b00};
    assign branch_target = pc + arm_exec_pkg::word_t'(8) + branch_offset;
    assign link_value    = pc + arm_exec_pkg::word_t'(4);

    assign next_update_rd = (is_data && alu_writes_rd) || is_link || mem_read_en;
    assign next_result    = is_branch ? link_value : alu_result;

    always_ff @(posedge clk) begin
        if (nreset) begin
            ready          <= 1'b0;
            executor_inst  <= '0;
            cpsr           <= '0;
            update_pc      <= 1'b0;
            new_pc         <= '0;
            update_rd      <= 1'b0;
            result_is_load <= 1'b0;
        end else begin
            ready <= enable;
            if (enable) begin
                executor_inst <= decoder_inst;
            end
            if (is_data && decoder_inst[`ARM_SET_FLAGS_BIT]) begin
                cpsr <= alu_flags;
            end
            update_pc <= is_branch;
            if (is_branch) begin
                new_pc <= branch_target;    // Held between branches
            end
            update_rd      <= next_update_rd;
            result_is_load <= mem_read_en;
        end
    end

    // Data or link value for the next cycle
    always_ff @(posedge clk) begin
        result_q <= next_result;
    end

    // Load data arrives from the memory one cycle after the address edge
    assign rd_value = !update_rd    ? '0 :
                      result_is_load ? mem_read_data : result_q;

endmodule

`default_nettype wire

// File: dv/exec_checker.sv
// Testbench checker for the execute stage
// Reference model with own flags and byte memory, comparison, per-test report
`timescale 1ns/1ps
`default_nettype none

`include "arm_exec_defines.svh"

module exec_checker (
    input  logic                 clk,
    input  logic                 nreset,
    input  logic                 enable,
    input  arm_exec_pkg::word_t  decoder_inst,
    input  arm_exec_pkg::word_t  rn_value,
    input  arm_exec_pkg::word_t  rd_rm_value,
    input  arm_exec_pkg::word_t  pc,
    input  int                   test_num,
    input  logic                 ready,
    input  arm_exec_pkg::flags_t cpsr,
    input  logic                 condition_passes,
    input  arm_exec_pkg::word_t  executor_inst,
    input  logic                 update_pc,
    input  arm_exec_pkg::word_t  new_pc,
    input  logic                 update_rd,
    input  arm_exec_pkg::word_t  rd_value,
    output int                   tests_passed,
    output int                   tests_failed
);

    logic [7:0]           ref_mem [0:`ARM_DATA_SIZE-1];
    arm_exec_pkg::flags_t ref_flags;
    arm_exec_pkg::word_t  exp_inst;
    arm_exec_pkg::word_t  exp_new_pc;
    arm_exec_pkg::word_t  exp_rd_value;
    logic                 exp_ready;
    logic                 exp_update_pc;
    logic                 exp_update_rd;
    logic                 cond_check;
    logic                 cond_exp;
    logic                 cond_act;
    logic                 armed;
    int                   cur_test;
    int                   errs;
    int                   base_errs;

    function automatic string test_name(input int n);
        case (n)
            1: return "reset_idle";
            2: return "data_processing";
            3: return "conditions";
            4: return "memory";
            5: return "branch";
            default: return "unknown";
        endcase
    endfunction

    // Left shift by 32 yields 0 when the amount is zero
    function automatic arm_exec_pkg::word_t rot_right(input arm_exec_pkg::word_t v,
                                                      input logic [4:0] n);
        return (v >> n) | (v << (6'd32 - {1'b0, n}));
    endfunction

    function automatic arm_exec_pkg::word_t shift_reg(input arm_exec_pkg::word_t inst,
                                                      input arm_exec_pkg::word_t rm);
        logic [4:0] amt;
        amt = inst[11:7];
        case (inst[6:5])
            2'd0: return rm << amt;
            2'd1: return rm >> amt;
            2'd2: return $signed(rm) >>> amt;
            default: return rot_right(rm, amt);
        endcase
    endfunction

    function automatic logic cond_ok(input arm_exec_pkg::flags_t f, input logic [3:0] c);
        case (c)
            4'd0: return f.z;
            4'd1: return !f.z;
            4'd2: return f.c;
            4'd3: return !f.c;
            4'd4: return f.n;
            4'd5: return !f.n;
            4'd6: return f.v;
            4'd7: return !f.v;
            4'd8: return f.c && !f.z;
            4'd9: return !f.c || f.z;
            4'd10: return f.n == f.v;
            4'd11: return f.n != f.v;
            4'd12: return !f.z && (f.n == f.v);
            4'd13: return f.z || (f.n != f.v);
            default: return 1'b1;
        endcase
    endfunction

    // Applies one accepted instruction to the model state and the expected outputs
    function automatic void predict(input arm_exec_pkg::word_t inst,
                                    input arm_exec_pkg::word_t rn,
                                    input arm_exec_pkg::word_t rdrm,
                                    input arm_exec_pkg::word_t pcv);
        arm_exec_pkg::word_t op2;
        arm_exec_pkg::word_t res;
        logic [32:0]         wide;
        logic [7:0]          addr;
        logic                writes;
        logic                known;
        exp_update_pc = 1'b0;
        exp_update_rd = 1'b0;
        exp_rd_value  = '0;
        if (!cond_ok(ref_flags, inst[31:28])) begin
            return;
        end
        case (inst[27:26])
            2'd0: begin
                op2 = inst[25] ? rot_right({24'b0, inst[7:0]}, {inst[11:8], 1'b0})
                               : shift_reg(inst, rdrm);
                writes = 1'b1;
                known  = 1'b1;
                wide   = '0;
                res    = '0;
                case (inst[24:21])
                    4'd1: res = rn ^ op2;
                    4'd2, 4'd10: begin
                        res  = rn - op2;
                        wide = {1'b0, rn >= op2, 31'b0};
                        wide[0] = (rn[31] != op2[31]) && (res[31] != rn[31]);
                    end
                    4'd4: begin
                        wide = {1'b0, rn} + {1'b0, op2};
                        res  = wide[31:0];
                        wide = {1'b0, wide[32], 31'b0};
                        wide[0] = (rn[31] == op2[31]) && (res[31] != rn[31]);
                    end
                    4'd8: res = rn & op2;
                    4'd9: res = rn ^ op2;
                    4'd12: res = rn | op2;
                    4'd13: res = op2;
                    4'd14: res = rn & ~op2;
                    4'd15: res = ~op2;
                    default: known = 1'b0;
                endcase
                if (!known || inst[24:21] inside {4'd8, 4'd9, 4'd10}) begin
                    writes = 1'b0;
                end
                if (known && inst[20]) begin
                    ref_flags = '{n: res[31], z: (res == 0), c: wide[31], v: wide[0]};
                end
                exp_update_rd = writes;
                exp_rd_value  = writes ? res : '0;
            end
            2'd1: begin
                op2  = inst[25] ? shift_reg(inst, rdrm) : {20'b0, inst[11:0]};
                res  = inst[23] ? rn + op2 : rn - op2;
                addr = res[7:0];
                if (inst[20]) begin
                    exp_update_rd = 1'b1;   // Big-endian word
                    exp_rd_value  = {ref_mem[addr], ref_mem[addr + 8'd1],
                                     ref_mem[addr + 8'd2], ref_mem[addr + 8'd3]};
                end else if (!inst[25]) begin
                    ref_mem[addr]        = rdrm[31:24];
                    ref_mem[addr + 8'd1] = rdrm[23:16];
                    ref_mem[addr + 8'd2] = rdrm[15:8];
                    ref_mem[addr + 8'd3] = rdrm[7:0];
                end
            end
            2'd2: begin
                exp_update_pc = 1'b1;
                exp_new_pc    = pcv + 32'd8 + {{6{inst[23]}}, inst[23:0], 2'b00};
                if (inst[24]) begin
                    exp_update_rd = 1'b1;
                    exp_rd_value  = pcv + 32'd4;
                end
            end
            default: ;
        endcase
    endfunction

    task automatic check_value(input string field, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            errs++;
            $display("FAIL %s %s: expected %h actual %h", test_name(cur_test), field, exp, act);
        end
    endtask

    initial begin
        armed        = 1'b0;
        cond_check   = 1'b0;
        cur_test     = 0;
        errs         = 0;
        base_errs    = 0;
        tests_passed = 0;
        tests_failed = 0;
    end

    always @(posedge clk) begin
        if (test_num != cur_test) begin     // Close the finished test
            if (cur_test > 0) begin
                if (errs == base_errs) begin
                    tests_passed++;
                    $display("PASS %s", test_name(cur_test));
                end else begin
                    tests_failed++;
                    $display("FAIL %s with %0d errors", test_name(cur_test),
                             errs - base_errs);
                end
            end
            cur_test  = test_num;
            base_errs = errs;
        end
        if (nreset) begin
            ref_flags     = '0;
            exp_inst      = '0;
            exp_new_pc    = '0;
            exp_ready     = 1'b0;
            exp_update_pc = 1'b0;
            exp_update_rd = 1'b0;
            exp_rd_value  = '0;
            cond_check    = 1'b0;
        end else begin
            exp_ready  = enable;
            cond_check = enable;
            if (enable) begin
                cond_exp = cond_ok(ref_flags, decoder_inst[31:28]);
                cond_act = condition_passes;    // Still sees the flags before this edge
                exp_inst = decoder_inst;
                predict(decoder_inst, rn_value, rd_rm_value, pc);
            end else begin
                exp_update_pc = 1'b0;
                exp_update_rd = 1'b0;
                exp_rd_value  = '0;
            end
        end
        armed = 1'b1;
    end

    // Registered outputs are settled half a cycle after the edge
    always @(negedge clk) begin
        if (armed) begin
            if (cond_check) begin
                check_value("condition_passes", {31'b0, cond_exp}, {31'b0, cond_act});
            end
            check_value("ready", {31'b0, exp_ready}, {31'b0, ready});
            check_value("executor_inst", exp_inst, executor_inst);
            check_value("cpsr", {28'b0, ref_flags}, {28'b0, cpsr});
            check_value("update_pc", {31'b0, exp_update_pc}, {31'b0, update_pc});
            check_value("new_pc", exp_new_pc, new_pc);
            check_value("update_rd", {31'b0, exp_update_rd}, {31'b0, update_rd});
            check_value("rd_value", exp_rd_value, rd_value);
        end
    end

endmodule

`default_nettype wire

// File: dv/tb_executor.sv
// Testbench top for the execute stage
// Clock, reset, directed and random stimulus, timeout
`timescale 1ns/1ps
`default_nettype none

module tb_executor;

    localparam int CYCLE_LIMIT = 2000;  // About 700 instructions plus reset and margin

    logic                 clk;
    logic                 nreset;
    logic                 enable;
    arm_exec_pkg::word_t  decoder_inst;
    arm_exec_pkg::word_t  rn_value;
    arm_exec_pkg::word_t  rd_rm_value;
    arm_exec_pkg::word_t  pc;
    logic                 ready;
    arm_exec_pkg::flags_t cpsr;
    logic                 condition_passes;
    arm_exec_pkg::word_t  executor_inst;
    logic                 update_pc;
    arm_exec_pkg::word_t  new_pc;
    logic                 update_rd;
    arm_exec_pkg::word_t  rd_value;
    int                   test_num;
    int                   tests_passed;
    int                   tests_failed;
    int                   cycles;
    integer               seed;
    logic [3:0]           kept_ops [0:9];

    executor dut (
        .clk(clk), .nreset(nreset), .enable(enable), .decoder_inst(decoder_inst),
        .rn_value(rn_value), .rd_rm_value(rd_rm_value), .pc(pc), .ready(ready),
        .cpsr(cpsr), .condition_passes(condition_passes), .executor_inst(executor_inst),
        .update_pc(update_pc), .new_pc(new_pc), .update_rd(update_rd), .rd_value(rd_value)
    );

    exec_checker chk (
        .clk(clk), .nreset(nreset), .enable(enable), .decoder_inst(decoder_inst),
        .rn_value(rn_value), .rd_rm_value(rd_rm_value), .pc(pc), .test_num(test_num),
        .ready(ready), .cpsr(cpsr), .condition_passes(condition_passes),
        .executor_inst(executor_inst), .update_pc(update_pc), .new_pc(new_pc),
        .update_rd(update_rd), .rd_value(rd_value),
        .tests_passed(tests_passed), .tests_failed(tests_failed)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("test failed");
            $finish;
        end
    end

    function automatic arm_exec_pkg::word_t make_data(input logic [3:0] cond,
            input logic [3:0] op, input logic imm, input logic s, input logic [11:0] low);
        return {cond, 2'b00, imm, op, s, 8'h00, low};
    endfunction

    function automatic arm_exec_pkg::word_t make_mem(input logic reg_off, input logic up,
                                                     input logic load, input logic [11:0] low);
        return {4'he, 2'b01, reg_off, 1'b0, up, 2'b00, load, 8'h00, low};
    endfunction

    function automatic arm_exec_pkg::word_t make_branch(input logic link,
                                                        input logic [23:0] off);
        return {4'he, 2'b10, 1'b0, link, off};
    endfunction

    task automatic issue(input arm_exec_pkg::word_t inst, input arm_exec_pkg::word_t rn,
                         input arm_exec_pkg::word_t rdrm, input arm_exec_pkg::word_t pcv);
        @(negedge clk);
        enable       = 1'b1;
        decoder_inst = inst;
        rn_value     = rn;
        rd_rm_value  = rdrm;
        pc           = pcv;
    endtask

    // Junk on the instruction bus while enable is low
    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            enable       = 1'b0;
            decoder_inst = $random(seed);
        end
    endtask

    task automatic random_data(input logic [3:0] cond, input logic [3:0] op);
        arm_exec_pkg::word_t rn;
        arm_exec_pkg::word_t rm;
        rn = $random(seed);
        rm = ($random(seed) % 4 == 0) ? rn : $random(seed);  // Equal operands give Z
        issue(make_data(cond, op, 1'($random(seed)), 1'($random(seed)), 12'($random(seed))),
              rn, rm, $random(seed));
    endtask

    initial begin
        int a;
        seed         = 32'ha2f5;
        kept_ops     = '{4'd1, 4'd2, 4'd4, 4'd8, 4'd9, 4'd10, 4'd12, 4'd13, 4'd14, 4'd15};
        cycles       = 0;
        test_num     = 1;   // Reset belongs to the first test
        nreset       = 1'b1;
        enable       = 1'b0;
        decoder_inst = '0;
        rn_value     = '0;
        rd_rm_value  = '0;
        pc           = '0;
        repeat (16) @(negedge clk);
        nreset = 1'b0;

        idle(3);
        repeat (3) random_data(4'he, 4'd13);
        idle(2);
        random_data(4'he, 4'd4);
        idle(2);

        test_num = 2;
        repeat (200) random_data(4'he, kept_ops[4'($unsigned($random(seed)) % 10)]);
        idle(2);

        test_num = 3;
        for (a = 0; a < 16; a++) begin
            random_data(4'he, ($random(seed) & 1) ? 4'd10 : 4'd4);
            random_data(4'he, ($random(seed) & 1) ? 4'd10 : 4'd4);
            // Flag-setting MOV, so a failing one shows cpsr unchanged
            issue(make_data(4'(a), 4'd13, 1'b1, 1'b1, 12'($random(seed))), '0, '0, '0);
        end
        idle(2);

        test_num = 4;
        for (a = 0; a < 64; a++) begin   // Fill every byte before any load
            issue(make_mem(1'b0, 1'b1, 1'b0, 12'(a * 4)), '0, $random(seed), '0);
        end
        repeat (80) begin
            issue(make_mem(1'b0, 1'($random(seed)), 1'b0, 12'($random(seed))),
                  $random(seed), $random(seed), '0);
            issue(make_mem(1'b0, 1'($random(seed)), 1'b1, 12'($random(seed))),
                  $random(seed), '0, '0);
            issue(make_mem(1'b1, 1'($random(seed)), 1'b1, 12'($random(seed))),
                  $random(seed), $random(seed), '0);
        end
        idle(2);

        test_num = 5;
        repeat (60) begin
            issue(make_branch(1'($random(seed)), 24'($random(seed))), '0, '0,
                  $random(seed) & 32'hffff_fffc);
        end
        idle(2);

        test_num = 6;   // Lets the checker close the last test
        idle(3);
        $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && tests_passed == 5) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+common
common/arm_exec_pkg.sv
alu/operand_shifter.sv
alu/dataproc_alu.sv
logic/condition_check.sv
logic/data_memory.sv
logic/executor.sv
dv/exec_checker.sv
dv/tb_executor.sv

// File: run.sh
#!/bin/bash
# Build and run the execute stage simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module tb_executor -o sim_executor

./obj_dir/sim_executor | tee sim.log

if grep -q "test failed" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi

if ! grep -q "test passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi

exit 0
